// File: logic/cache_defs.svh
// Cache geometry and bus width definitions for the L1 data cache
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// bus widths
`define WORD_W 32
`define ADDR_W 32

// both geometry sizes must be powers of two
`define CACHE_SETS 16
`define BLOCK_WORDS 2

// derived index widths
`define SET_BITS ($clog2(`CACHE_SETS))
`define WORD_SEL_BITS ($clog2(`BLOCK_WORDS))

// two low bits select the byte inside a word
`define TAG_BITS (`ADDR_W - `SET_BITS - `WORD_SEL_BITS - 2)

// one enable per byte of a data word
`define BYTE_EN_W (`WORD_W / 8)

`endif

// File: logic/cache_pkg.sv
// Cache package with the bus, frame and address types and the controller states
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    // processor address split into cache fields
    typedef struct packed {
        logic [`TAG_BITS-1:0]      tag;
        logic [`SET_BITS-1:0]      set_idx;
        logic [`WORD_SEL_BITS-1:0] word_sel;
        logic [1:0]                byte_off;
    } cache_addr_t;

    // one frame per set
    typedef struct packed {
        logic                          valid;
        logic                          dirty;
        logic [`TAG_BITS-1:0]          tag;
        word_t [`BLOCK_WORDS-1:0]      data;
    } frame_t;

    typedef struct packed {
        logic                  ren;
        logic                  wen;
        logic [`ADDR_W-1:0]    addr;
        word_t                 wdata;
        logic [`BYTE_EN_W-1:0] byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    typedef struct packed {
        logic               ren;
        logic               wen;
        logic [`ADDR_W-1:0] addr;
        word_t              wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        INIT,
        READY,
        WRITEBACK,
        FETCH,
        FLUSH
    } cache_state_e;

endpackage

`default_nettype wire

// File: logic/frame_store.sv
// Frame store holding one cache frame per set with a bit-masked write
`default_nettype none

`include "cache_defs.svh"

module frame_store (
    input  logic                  CLK,
    input  logic [`SET_BITS-1:0]  set_sel,
    input  logic                  wen,
    input  cache_pkg::frame_t     wdata,
    input  cache_pkg::frame_t     mask,
    output cache_pkg::frame_t     rdata
);

    cache_pkg::frame_t frames [`CACHE_SETS];
    cache_pkg::frame_t merged;

    // read port is asynchronous so hit detection fits in one cycle
    assign rdata = frames[set_sel];

    // a zero mask bit takes the new value, a one keeps the stored bit
    assign merged = (frames[set_sel] & mask) | (wdata & ~mask);

    always_ff @(posedge CLK) begin
        if (wen) begin
            frames[set_sel] <= merged;
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
// Cache controller FSM for hits, block fill, victim write-back and flush
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    output logic                  flush_done,
    input  cache_pkg::proc_req_t  proc_req,
    output cache_pkg::proc_rsp_t  proc_rsp,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::mem_rsp_t   mem_rsp,
    output logic [`SET_BITS-1:0]  set_sel,
    output logic                  store_wen,
    output cache_pkg::frame_t     store_wdata,
    output cache_pkg::frame_t     store_mask,
    input  cache_pkg::frame_t     store_rdata
);

    cache_pkg::cache_state_e state, next_state;
    logic flush_req, next_flush_req;
    logic next_flush_done;
    logic [`WORD_SEL_BITS-1:0] word_cnt, next_word_cnt;
    logic [`SET_BITS-1:0] set_cnt, next_set_cnt;

    cache_pkg::cache_addr_t req_addr;
    logic access;
    logic hit;
    logic last_word;
    logic last_set;
    logic frame_done;
    logic [`WORD_W-1:0] byte_mask;

    assign req_addr  = cache_pkg::cache_addr_t'(proc_req.addr);
    assign access    = proc_req.ren || proc_req.wen;
    assign hit       = store_rdata.valid && (store_rdata.tag == req_addr.tag);
    assign last_word = (word_cnt == (`WORD_SEL_BITS)'(`BLOCK_WORDS - 1));
    assign last_set  = (set_cnt == (`SET_BITS)'(`CACHE_SETS - 1));

    // expand byte enables to a bit mask
    always_comb begin
        for (int i = 0; i < `BYTE_EN_W; i++) begin
            byte_mask[8*i +: 8] = {8{proc_req.byte_en[i]}};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= cache_pkg::INIT;
            flush_req  <= 1'b0;
            flush_done <= 1'b0;
            word_cnt   <= '0;
            set_cnt    <= '0;
        end else begin
            state      <= next_state;
            flush_req  <= next_flush_req;
            flush_done <= next_flush_done;
            word_cnt   <= next_word_cnt;
            set_cnt    <= next_set_cnt;
        end
    end

    // keep a flush that shows up mid-miss until READY can take it
    always_comb begin
        next_flush_req = flush_req;
        if (flush) begin
            next_flush_req = 1'b1;
        end
        if (state == cache_pkg::FLUSH) begin
            next_flush_req = 1'b0;
        end
    end

    always_comb begin
        next_state      = state;
        next_word_cnt   = word_cnt;
        next_set_cnt    = set_cnt;
        next_flush_done = 1'b0;
        frame_done      = 1'b0;
        set_sel         = req_addr.set_idx;
        store_wen       = 1'b0;
        store_wdata     = '0;
        store_mask      = '1;
        proc_rsp.busy   = 1'b1;
        proc_rsp.rdata  = store_rdata.data[req_addr.word_sel];
        mem_req         = '0;

        case (state)
            cache_pkg::INIT: begin
                // wipe one set per cycle
                set_sel      = set_cnt;
                store_wen    = 1'b1;
                store_mask   = '0;
                next_set_cnt = set_cnt + 1'b1;
                if (last_set) begin
                    next_set_cnt = '0;
                    next_state   = cache_pkg::READY;
                end
            end

            cache_pkg::READY: begin
                if (flush || flush_req) begin
                    next_state = cache_pkg::FLUSH;
                end else if (access && hit) begin
                    proc_rsp.busy = 1'b0;
                    if (proc_req.wen) begin
                        // only the enabled bytes of the addressed word change
                        store_wen                           = 1'b1;
                        store_wdata.dirty                   = 1'b1;
                        store_mask.dirty                    = 1'b0;
                        store_wdata.data[req_addr.word_sel] = proc_req.wdata;
                        store_mask.data[req_addr.word_sel]  = ~byte_mask;
                    end
                end else if (access) begin
                    next_word_cnt = '0;
                    if (store_rdata.valid && store_rdata.dirty) begin
                        next_state = cache_pkg::WRITEBACK;
                    end else begin
                        next_state = cache_pkg::FETCH;
                    end
                end
            end

            cache_pkg::WRITEBACK: begin
                // victim address is rebuilt from the stored tag
                mem_req.wen   = 1'b1;
                mem_req.addr  = {store_rdata.tag, req_addr.set_idx, word_cnt, 2'b00};
                mem_req.wdata = store_rdata.data[word_cnt];
                if (!mem_rsp.busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    if (last_word) begin
                        store_wen        = 1'b1;
                        store_mask.dirty = 1'b0;
                        next_word_cnt    = '0;
                        next_state       = cache_pkg::FETCH;
                    end
                end
            end

            cache_pkg::FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_addr.tag, req_addr.set_idx, word_cnt, 2'b00};
                if (!mem_rsp.busy) begin
                    // frame stays invalid until its last word lands
                    store_wen                  = 1'b1;
                    store_wdata.data[word_cnt] = mem_rsp.rdata;
                    store_mask.data[word_cnt]  = '0;
                    store_wdata.tag            = req_addr.tag;
                    store_mask.tag             = '0;
                    store_wdata.valid          = last_word;
                    store_mask.valid           = 1'b0;
                    next_word_cnt              = word_cnt + 1'b1;
                    if (last_word) begin
                        next_word_cnt = '0;
                        next_state    = cache_pkg::READY;
                    end
                end
            end

            cache_pkg::FLUSH: begin
                set_sel = set_cnt;
                if (store_rdata.valid && store_rdata.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {store_rdata.tag, set_cnt, word_cnt, 2'b00};
                    mem_req.wdata = store_rdata.data[word_cnt];
                    if (!mem_rsp.busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                        frame_done    = last_word;
                    end
                end else begin
                    frame_done = 1'b1;
                end

                // clear the frame and move on to the next set
                if (frame_done) begin
                    store_wen     = 1'b1;
                    store_mask    = '0;
                    next_word_cnt = '0;
                    next_set_cnt  = set_cnt + 1'b1;
                    if (last_set) begin
                        next_set_cnt    = '0;
                        next_flush_done = 1'b1;
                        next_state      = cache_pkg::READY;
                    end
                end
            end

            default: begin
                next_state = cache_pkg::INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/l1_cache.sv
// Direct-mapped write-back L1 data cache between a processor port and memory
`default_nettype none

`include "cache_defs.svh"

module l1_cache (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    output logic                  flush_done,
    input  cache_pkg::proc_req_t  proc_req,
    output cache_pkg::proc_rsp_t  proc_rsp,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::mem_rsp_t   mem_rsp
);

    // controller to frame store
    logic [`SET_BITS-1:0] set_sel;
    logic                 store_wen;
    cache_pkg::frame_t    store_wdata;
    cache_pkg::frame_t    store_mask;
    cache_pkg::frame_t    store_rdata;

    cache_ctrl ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .flush_done  (flush_done),
        .proc_req    (proc_req),
        .proc_rsp    (proc_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .set_sel     (set_sel),
        .store_wen   (store_wen),
        .store_wdata (store_wdata),
        .store_mask  (store_mask),
        .store_rdata (store_rdata)
    );

    frame_store store (
        .CLK     (CLK),
        .set_sel (set_sel),
        .wen     (store_wen),
        .wdata   (store_wdata),
        .mask    (store_mask),
        .rdata   (store_rdata)
    );

endmodule

`default_nettype wire

// File: tests/l1_cache_props.sv
// Concurrent checks on the cache memory bus, busy during INIT and the flush pulse
`default_nettype none

`include "cache_defs.svh"

module l1_cache_props (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 flush_done,
    input cache_pkg::proc_req_t proc_req,
    input cache_pkg::proc_rsp_t proc_rsp,
    input cache_pkg::mem_req_t  mem_req,
    input cache_pkg::mem_rsp_t  mem_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic [`SET_BITS:0] init_cycles;

    // counts cycles after reset until every set is cleared
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_cycles <= '0;
        end else if (init_cycles < `CACHE_SETS) begin
            init_cycles <= init_cycles + 1'b1;
        end
    end

    init_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (init_cycles < `CACHE_SETS) |-> proc_rsp.busy)
        else begin
            $error("processor port not busy while the sets are being cleared");
            fail_count++;
        end

    // a completed read hit never touches memory
    hit_no_fetch: assert property (@(posedge CLK) disable iff (!nRST)
        (proc_req.ren && !proc_rsp.busy) |-> !mem_req.ren)
        else begin
            $error("memory read issued during a read hit");
            fail_count++;
        end

    bus_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            $error("memory read and write requested together");
            fail_count++;
        end

    addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req.addr))
        else begin
            $error("memory address changed while memory was busy");
            fail_count++;
        end

    flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            $error("flush_done stayed high for more than one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tests/l1_cache_tb.sv
// Testbench for the L1 cache with a memory model that inserts random wait states
`default_nettype none

`include "cache_defs.svh"

module l1_cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // 40 accesses x 2 words x 2 phases x 4 cycles plus a 16-set flush and a margin
    localparam int CYCLE_LIMIT = 4000;
    localparam logic [31:0] FILL_KEY = 32'h5A3C_96E1;

    logic CLK;
    logic nRST;
    logic flush;
    logic flush_done;
    cache_pkg::proc_req_t proc_req;
    cache_pkg::proc_rsp_t proc_rsp;
    cache_pkg::mem_req_t  mem_req;
    cache_pkg::mem_rsp_t  mem_rsp;

    // memory contents and the contents a processor should see
    cache_pkg::word_t mem [1024];
    cache_pkg::word_t ref_mem [1024];
    int errors = 0;
    int wr_count = 0;
    int rd_count = 0;
    int cycles;

    l1_cache uut (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    bind l1_cache l1_cache_props props (
        .CLK(CLK), .nRST(nRST), .flush_done(flush_done), .proc_req(proc_req),
        .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    function automatic cache_pkg::word_t init_word(input logic [31:0] addr);
        return addr ^ FILL_KEY;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic check(input string name, input cache_pkg::word_t expected,
                         input cache_pkg::word_t actual);
        assert (actual == expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // one processor access that starts and ends 1 ns after a rising edge
    task automatic access(input string name, input logic is_write, input logic [31:0] addr,
                          input cache_pkg::word_t wdata, input logic [3:0] byte_en);
        logic [9:0] idx;
        idx = addr[11:2];
        proc_req.ren = !is_write;
        proc_req.wen = is_write;
        proc_req.addr = addr;
        proc_req.wdata = wdata;
        proc_req.byte_en = byte_en;
        do begin
            @(negedge CLK);
        end while (proc_rsp.busy);
        if (is_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    ref_mem[idx][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end else begin
            check(name, ref_mem[idx], proc_rsp.rdata);
        end
        @(posedge CLK);
        #1;
        proc_req = '0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    // memory model completes a word in the first cycle with busy low
    initial begin
        logic [15:0] lfsr;
        logic [9:0] idx;
        int wait_left;
        logic armed;
        lfsr = 16'd4;
        wait_left = 0;
        armed = 1'b0;
        mem_rsp = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = init_word(32'(i) << 2);
        end
        forever begin
            @(posedge CLK);
            #1;
            idx = mem_req.addr[11:2];
            if (!mem_req.ren && !mem_req.wen) begin
                armed = 1'b0;
                mem_rsp.busy = 1'b0;
            end else begin
                if (!armed) begin
                    // two LFSR bits give 0 to 3 wait cycles
                    wait_left = 0;
                    repeat (2) begin
                        wait_left = wait_left * 2 + int'(lfsr[0]);
                        lfsr = lfsr_next(lfsr);
                    end
                    armed = 1'b1;
                end
                mem_rsp.busy = (wait_left > 0);
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    mem_rsp.rdata = mem[idx];
                    armed = 1'b0;
                end
            end
            @(negedge CLK);
            if (mem_req.wen && !mem_rsp.busy) begin
                check("mem_write", ref_mem[idx], mem_req.wdata);
                mem[idx] = mem_req.wdata;
                wr_count++;
            end
            if (mem_req.ren && !mem_rsp.busy) begin
                rd_count++;
            end
        end
    end

    initial begin
        int w0;
        int r0;
        flush = 1'b0;
        nRST = 1'b0;
        proc_req = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = init_word(32'(i) << 2);
        end
        // read held through reset and INIT
        proc_req.ren = 1'b1;
        proc_req.addr = 32'h40;
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        access("init_read", 1'b0, 32'h40, '0, '0);
        r0 = rd_count;
        access("block_hit", 1'b0, 32'h44, '0, '0);
        check("block_hit_fetches", 32'd0, rd_count - r0);
        access("byte_write", 1'b1, 32'h44, 32'hDEAD_BEEF, 4'b0101);
        access("byte_read", 1'b0, 32'h44, '0, '0);
        // 0xC0 shares the set of the dirty 0x40 block
        w0 = wr_count;
        r0 = rd_count;
        access("conflict_read", 1'b0, 32'hC0, '0, '0);
        check("victim_writes", 32'd2, wr_count - w0);
        check("conflict_fetches", 32'd2, rd_count - r0);
        for (int i = 0; i < 6; i++) begin
            access("flush_write", 1'b1, 32'h100 + 32'(i * 8),
                   32'h1357_9BDF * 32'(i + 1), 4'b0011 << (i % 3));
        end
        w0 = wr_count;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        do begin
            @(negedge CLK);
        end while (!flush_done);
        @(posedge CLK);
        #1;
        check("flush_writes", 32'd12, wr_count - w0);
        for (int i = 0; i < 1024; i++) begin
            check("flush_mem", ref_mem[i], mem[i]);
        end
        r0 = rd_count;
        access("refetch_read", 1'b0, 32'h108, '0, '0);
        check("refetch_fetches", 32'd2, rd_count - r0);
        $display("summary: %0d data check errors, %0d assertion failures",
                 errors, uut.props.fail_count);
        if (errors == 0 && uut.props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/cache_pkg.sv
logic/frame_store.sv
logic/cache_ctrl.sv
logic/l1_cache.sv
tests/l1_cache_props.sv
tests/l1_cache_tb.sv

// File: Makefile
TOP := l1_cache_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		test $$status -eq 0 && ! grep -q "Testbench failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
